//--- rtl/glbl_pkg.sv
// Shared definitions of the global register block
// Bus widths, word addresses, reset and identity values
// LFSR constants, grouped-signal structs and byte-enable helpers

`default_nettype none

package glbl_pkg;

   // --------------------
   // Widths and base types
   localparam int DATA_W   = 32;
   localparam int ADDR_W   = 5;
   localparam int SEL_W    = 4;
   localparam int NUM_REGS = 32;
   localparam int SW_NUM   = 8;

   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [SEL_W-1:0]    sel_t;
   typedef logic [NUM_REGS-1:0] strobe_t;

   // --------------------
   // Word addresses
   localparam addr_t ADR_CHIP_ID   = 5'h00;
   localparam addr_t ADR_RST_CTRL  = 5'h01;
   localparam addr_t ADR_CORE_CFG  = 5'h02;
   localparam addr_t ADR_INTR_MASK = 5'h03;
   localparam addr_t ADR_INTR_STAT = 5'h04;
   localparam addr_t ADR_MFUNC_SEL = 5'h05;
   localparam addr_t ADR_RANDOM    = 5'h09;
   localparam addr_t ADR_INTR_SET  = 5'h0A;
   localparam addr_t ADR_STRAP     = 5'h0E;
   localparam addr_t ADR_MAILBOX   = 5'h0F;
   localparam addr_t ADR_SW_BASE   = 5'h10;

   // Identity and reset values
   localparam data_t CHIP_ID_VAL   = 32'h8268_2701;
   localparam data_t RST_CTRL_BOOT = 32'h0000_0103;
   localparam data_t RST_CTRL_HOLD = 32'h0000_0003;
   localparam data_t SW_SIG_VAL    = 32'h8273_8343;
   localparam data_t SW_DATE_VAL   = 32'h0101_2025;
   localparam data_t SW_REV_VAL    = 32'h0005_2000;

   // Galois taps and default seed
   localparam data_t LFSR_POLY     = 32'h8020_0003;
   localparam data_t LFSR_SEED_DEF = 32'hACE1_2468;

   // --------------------
   // Structs
   typedef struct packed {
      logic        riscv_boot;
      logic        cache_bypass;
      logic        sram_clk_edge;
      logic [12:0] spare;
   } strap_t;

   typedef struct packed {
      strobe_t strobe;
      data_t   data;
      sel_t    sel;
   } wr_req_t;

   // All active low
   typedef struct packed {
      logic       cpu_intf;
      logic       qspim;
      logic       sspim;
      logic [2:0] uart;
      logic [1:0] i2cm;
      logic       usbh;
      logic       usbd;
      logic [3:0] cpu_core;
      logic       sspis;
   } periph_rst_t;

   typedef struct packed {
      logic [15:0] riscv_ctrl;
      logic        gpio_dgmode;
      logic        soft_irq;
      logic [2:0]  user_irq;
   } core_cfg_t;

   typedef struct packed {
      data_t                rst_ctrl;
      data_t                core_cfg;
      data_t                mfunc_sel;
      data_t                mailbox;
      data_t [SW_NUM-1:0]   sw;
   } cfg_rd_t;

   typedef struct packed {
      logic [23:0] gpio;
      logic        ir;
      logic        rtc;
      logic        pwm;
      logic        usbh;
      logic        usbd;
      logic        i2cm;
      logic [2:0]  timer;
   } intr_src_t;

   // Byte enables expanded to a bit mask
   function automatic data_t byte_mask(input sel_t sel);
      data_t m;
      for (int b = 0; b < SEL_W; b++) begin
         m[8*b +: 8] = {8{sel[b]}};
      end
      return m;
   endfunction

   // Old word with enabled bytes replaced
   function automatic data_t byte_merge(input data_t old_val, input data_t new_val,
                                        input sel_t sel);
      data_t m;
      m = byte_mask(sel);
      return (old_val & ~m) | (new_val & m);
   endfunction

endpackage

`default_nettype wire

//--- rtl/glbl_wb_slave.sv
// Wishbone classic slave front end
// Single-cycle ack with registered read data
// One-hot write strobe decode and read multiplexer

`default_nettype none

module glbl_wb_slave (
   input  wire logic                  mclk,
   input  wire logic                  s_reset_n,
   input  wire logic                  wb_cyc,
   input  wire logic                  wb_stb,
   input  wire logic                  wb_we,
   input  wire glbl_pkg::addr_t       wb_adr,
   input  wire glbl_pkg::data_t       wb_dat_w,
   input  wire glbl_pkg::sel_t        wb_sel,
   input  wire glbl_pkg::cfg_rd_t     cfg_rd,
   input  wire glbl_pkg::data_t       intr_mask,
   input  wire glbl_pkg::data_t       intr_stat,
   input  wire glbl_pkg::data_t       random,
   input  wire glbl_pkg::strap_t      strap,
   output glbl_pkg::data_t            wb_dat_r,
   output logic                       wb_ack,
   output glbl_pkg::wr_req_t          wr_req,
   output logic                       acc_done
);
   import glbl_pkg::*;

   data_t rd_word;
   logic  wr_commit;

   // --------------------
   // Ack and read capture
   // Request seen while ack low, ack next cycle
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         wb_ack   <= 1'b0;
         wb_dat_r <= '0;
      end else if (wb_cyc && wb_stb && !wb_ack) begin
         wb_ack   <= 1'b1;
         wb_dat_r <= rd_word;
      end else begin
         wb_ack   <= 1'b0;
      end
   end

   // LFSR steps on every completed access
   assign acc_done = wb_ack;

   // --------------------
   // Write strobe
   // Only in the ack cycle, so each write commits once
   assign wr_commit = wb_cyc & wb_stb & wb_we & wb_ack;

   always_comb begin
      wr_req.strobe = wr_commit ? (strobe_t'(1) << wb_adr) : '0;
      wr_req.data   = wb_dat_w;
      wr_req.sel    = wb_sel;
   end

   // --------------------
   // Read multiplexer
   always_comb begin
      rd_word = '0;
      case (wb_adr)
         ADR_CHIP_ID   : rd_word = CHIP_ID_VAL;
         ADR_RST_CTRL  : rd_word = cfg_rd.rst_ctrl;
         ADR_CORE_CFG  : rd_word = cfg_rd.core_cfg;
         ADR_INTR_MASK : rd_word = intr_mask;
         ADR_INTR_STAT : rd_word = intr_stat;
         ADR_MFUNC_SEL : rd_word = cfg_rd.mfunc_sel;
         ADR_RANDOM    : rd_word = random;
         // Set register reads back the status
         ADR_INTR_SET  : rd_word = intr_stat;
         ADR_STRAP     : rd_word = {{(DATA_W-$bits(strap_t)){1'b0}}, strap};
         ADR_MAILBOX   : rd_word = cfg_rd.mailbox;
         default : begin
            // Software bank at 0x10 to 0x17, rest reads zero
            if (wb_adr[ADDR_W-1:3] == ADR_SW_BASE[ADDR_W-1:3]) begin
               rd_word = cfg_rd.sw[wb_adr[2:0]];
            end
         end
      endcase
   end

   // Ack lasts exactly one cycle
   a_ack_single : assert property (@(posedge mclk) disable iff (!s_reset_n)
      wb_ack |=> !wb_ack);

   // Never more than one register written per access
   a_strobe_onehot : assert property (@(posedge mclk) disable iff (!s_reset_n)
      $onehot0(wr_req.strobe));

endmodule

`default_nettype wire

//--- rtl/glbl_cfg_regs.sv
// Configuration register bank
// Reset control, core configuration, pin select, mailbox
// Eight software registers, all with per-byte writes
// Decode of reset control and core configuration outputs

`default_nettype none

module glbl_cfg_regs #(
   parameter glbl_pkg::data_t MFUNC_RESET = 32'hC000_0000
) (
   input  wire logic                  mclk,
   input  wire logic                  s_reset_n,
   input  wire glbl_pkg::wr_req_t     wr_req,
   input  wire glbl_pkg::strap_t      strap,
   output glbl_pkg::cfg_rd_t          cfg_rd,
   output glbl_pkg::periph_rst_t      periph_rst,
   output glbl_pkg::core_cfg_t        core_cfg,
   output glbl_pkg::data_t            mfunc_sel
);
   import glbl_pkg::*;

   // Register slots in the bank
   localparam int IDX_RST   = 0;
   localparam int IDX_CORE  = 1;
   localparam int IDX_MFUNC = 2;
   localparam int IDX_MBOX  = 3;
   localparam int IDX_SW0   = 4;
   localparam int NUM_CFG   = IDX_SW0 + SW_NUM;

   data_t              cfg_q   [NUM_CFG];
   data_t              rst_val [NUM_CFG];
   logic [NUM_CFG-1:0] wr_en;

   // --------------------
   // Reset values
   // Registers 1 and 2 follow the straps
   always_comb begin
      for (int i = 0; i < NUM_CFG; i++) begin
         rst_val[i] = '0;
      end
      // Boot strap releases the core reset bit 8
      rst_val[IDX_RST]   = strap.riscv_boot ? RST_CTRL_BOOT : RST_CTRL_HOLD;
      // Cache bypass in 27:26, SRAM clock edge in 19:16
      rst_val[IDX_CORE]  = {4'h0, {2{strap.cache_bypass}}, 6'h00,
                            {4{strap.sram_clk_edge}}, 16'h0000};
      rst_val[IDX_MFUNC] = MFUNC_RESET;
      // Signature, release date, revision
      rst_val[IDX_SW0]   = SW_SIG_VAL;
      rst_val[IDX_SW0+1] = SW_DATE_VAL;
      rst_val[IDX_SW0+2] = SW_REV_VAL;
   end

   // --------------------
   // Write enables from the one-hot strobe
   always_comb begin
      wr_en[IDX_RST]   = wr_req.strobe[ADR_RST_CTRL];
      wr_en[IDX_CORE]  = wr_req.strobe[ADR_CORE_CFG];
      wr_en[IDX_MFUNC] = wr_req.strobe[ADR_MFUNC_SEL];
      wr_en[IDX_MBOX]  = wr_req.strobe[ADR_MAILBOX];
      for (int i = 0; i < SW_NUM; i++) begin
         wr_en[IDX_SW0+i] = wr_req.strobe[ADR_SW_BASE + addr_t'(i)];
      end
   end

   // --------------------
   // Register bank
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         for (int i = 0; i < NUM_CFG; i++) begin
            cfg_q[i] <= rst_val[i];
         end
      end else begin
         for (int i = 0; i < NUM_CFG; i++) begin
            if (wr_en[i]) begin
               cfg_q[i] <= byte_merge(cfg_q[i], wr_req.data, wr_req.sel);
            end
         end
      end
   end

   // Read-back to the bus slave
   always_comb begin
      cfg_rd.rst_ctrl  = cfg_q[IDX_RST];
      cfg_rd.core_cfg  = cfg_q[IDX_CORE];
      cfg_rd.mfunc_sel = cfg_q[IDX_MFUNC];
      cfg_rd.mailbox   = cfg_q[IDX_MBOX];
      for (int i = 0; i < SW_NUM; i++) begin
         cfg_rd.sw[i] = cfg_q[IDX_SW0+i];
      end
   end

   // --------------------
   // Peripheral resets, bit 13 shared by uart2 and i2c1
   always_comb begin
      periph_rst.cpu_intf = cfg_q[IDX_RST][0];
      periph_rst.qspim    = cfg_q[IDX_RST][1];
      periph_rst.sspim    = cfg_q[IDX_RST][2];
      periph_rst.uart[0]  = cfg_q[IDX_RST][3];
      periph_rst.i2cm[0]  = cfg_q[IDX_RST][4];
      periph_rst.usbh     = cfg_q[IDX_RST][5];
      periph_rst.uart[1]  = cfg_q[IDX_RST][6];
      periph_rst.usbd     = cfg_q[IDX_RST][7];
      periph_rst.cpu_core = cfg_q[IDX_RST][11:8];
      periph_rst.sspis    = cfg_q[IDX_RST][12];
      periph_rst.uart[2]  = cfg_q[IDX_RST][13];
      periph_rst.i2cm[1]  = cfg_q[IDX_RST][13];
   end

   // Core configuration fields
   always_comb begin
      core_cfg.riscv_ctrl  = cfg_q[IDX_CORE][31:16];
      core_cfg.gpio_dgmode = cfg_q[IDX_CORE][8];
      core_cfg.soft_irq    = cfg_q[IDX_CORE][3];
      core_cfg.user_irq    = cfg_q[IDX_CORE][2:0];
   end

   // Pin mux select straight from the register
   assign mfunc_sel = cfg_q[IDX_MFUNC];

endmodule

`default_nettype wire

//--- rtl/glbl_intr_ctrl.sv
// Interrupt controller
// Two-flop synchronizers for the asynchronous sources
// Mask register, status with set and write-one-to-clear
// Masked interrupt lines

`default_nettype none

module glbl_intr_ctrl (
   input  wire logic                  mclk,
   input  wire logic                  s_reset_n,
   input  wire glbl_pkg::wr_req_t     wr_req,
   input  wire glbl_pkg::intr_src_t   intr_src,
   output glbl_pkg::data_t            intr_mask,
   output glbl_pkg::data_t            intr_stat,
   output glbl_pkg::data_t            irq_lines
);
   import glbl_pkg::*;

   // Synchronized sources in the order ir rtc usbh usbd i2cm
   localparam int NUM_SYNC = 5;

   logic [NUM_SYNC-1:0] sync_s1;
   logic [NUM_SYNC-1:0] sync_s2;
   data_t               hw_req;
   data_t               sw_set;
   data_t               sw_clr;
   data_t               wr_bits;

   // --------------------
   // Double synchronizer
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         sync_s1 <= '0;
         sync_s2 <= '0;
      end else begin
         sync_s1 <= {intr_src.ir, intr_src.rtc, intr_src.usbh,
                     intr_src.usbd, intr_src.i2cm};
         sync_s2 <= sync_s1;
      end
   end

   // Request word with USB host and device sharing bit 4
   // gpio pwm and timer are already in the mclk domain
   assign hw_req = {intr_src.gpio,
                    sync_s2[4],
                    sync_s2[3],
                    intr_src.pwm,
                    sync_s2[2] | sync_s2[1],
                    sync_s2[0],
                    intr_src.timer};

   // --------------------
   // Software set and clear with byte enables
   assign wr_bits = wr_req.data & byte_mask(wr_req.sel);
   assign sw_set  = wr_req.strobe[ADR_INTR_SET]  ? wr_bits : '0;
   assign sw_clr  = wr_req.strobe[ADR_INTR_STAT] ? wr_bits : '0;

   // Mask register
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_mask <= '0;
      end else if (wr_req.strobe[ADR_INTR_MASK]) begin
         intr_mask <= byte_merge(intr_mask, wr_req.data, wr_req.sel);
      end
   end

   // Status where set wins over clear
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_stat <= '0;
      end else begin
         intr_stat <= (intr_stat & ~sw_clr) | hw_req | sw_set;
      end
   end

   // Masked lines to the core
   assign irq_lines = intr_mask & intr_stat;

   // A request lands in status even under a clear in the same cycle
   a_set_wins : assert property (@(posedge mclk) disable iff (!s_reset_n)
      ((hw_req | sw_set) != '0) |=>
         ((intr_stat & $past(hw_req | sw_set)) == $past(hw_req | sw_set)));

endmodule

`default_nettype wire

//--- rtl/glbl_lfsr.sv
// Random number source
// 32-bit Galois LFSR stepped once per bus access

`default_nettype none

module glbl_lfsr #(
   parameter glbl_pkg::data_t SEED = glbl_pkg::LFSR_SEED_DEF
) (
   input  wire logic             mclk,
   input  wire logic             s_reset_n,
   input  wire logic             acc_done,
   output glbl_pkg::data_t       random
);
   import glbl_pkg::*;

   data_t lfsr_q;

   // Shift right, fold taps back when bit 0 falls out
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         lfsr_q <= SEED;
      end else if (acc_done) begin
         lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_POLY : '0);
      end
   end

   assign random = lfsr_q;

   // All-zero state would lock the generator
   a_never_zero : assert property (@(posedge mclk) disable iff (!s_reset_n)
      lfsr_q != '0);

endmodule

`default_nettype wire

//--- rtl/glbl_reg_top.sv
// Global register block top level
// Wishbone slave, configuration bank, interrupts, LFSR

`default_nettype none

module glbl_reg_top #(
   parameter glbl_pkg::data_t MFUNC_RESET = 32'hC000_0000,
   parameter glbl_pkg::data_t LFSR_SEED   = glbl_pkg::LFSR_SEED_DEF
) (
   input  wire logic                  mclk,
   input  wire logic                  s_reset_n,
   // Wishbone classic slave
   input  wire logic                  wb_cyc,
   input  wire logic                  wb_stb,
   input  wire logic                  wb_we,
   input  wire glbl_pkg::addr_t       wb_adr,
   input  wire glbl_pkg::data_t       wb_dat_w,
   input  wire glbl_pkg::sel_t        wb_sel,
   output glbl_pkg::data_t            wb_dat_r,
   output logic                       wb_ack,
   // Straps and interrupt sources
   input  wire glbl_pkg::strap_t      strap,
   input  wire glbl_pkg::intr_src_t   intr_src,
   // System outputs
   output glbl_pkg::periph_rst_t      periph_rst,
   output glbl_pkg::core_cfg_t        core_cfg,
   output glbl_pkg::data_t            mfunc_sel,
   output glbl_pkg::data_t            irq_lines
);
   import glbl_pkg::*;

   wr_req_t wr_req;
   logic    acc_done;
   cfg_rd_t cfg_rd;
   data_t   intr_mask;
   data_t   intr_stat;
   data_t   random;

   // --------------------
   // Bus front end
   glbl_wb_slave u_wb_slave (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_sel    (wb_sel),
      .cfg_rd    (cfg_rd),
      .intr_mask (intr_mask),
      .intr_stat (intr_stat),
      .random    (random),
      .strap     (strap),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .wr_req    (wr_req),
      .acc_done  (acc_done)
   );

   // Configuration bank
   glbl_cfg_regs #(
      .MFUNC_RESET (MFUNC_RESET)
   ) u_cfg_regs (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .wr_req     (wr_req),
      .strap      (strap),
      .cfg_rd     (cfg_rd),
      .periph_rst (periph_rst),
      .core_cfg   (core_cfg),
      .mfunc_sel  (mfunc_sel)
   );

   // Interrupts
   glbl_intr_ctrl u_intr_ctrl (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .wr_req    (wr_req),
      .intr_src  (intr_src),
      .intr_mask (intr_mask),
      .intr_stat (intr_stat),
      .irq_lines (irq_lines)
   );

   // Random number
   glbl_lfsr #(
      .SEED (LFSR_SEED)
   ) u_lfsr (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .acc_done  (acc_done),
      .random    (random)
   );

endmodule

`default_nettype wire

//--- bench/glbl_reg_tb.sv
// Testbench for the global register block
// Clock, reset, Wishbone tasks and a register model
// Reference functions, compare tasks and the test sequence

`default_nettype none

module glbl_reg_tb;
   import glbl_pkg::*;

   localparam int    ack_limit  = 16;
   localparam int    poll_limit = 20;
   localparam data_t lfsr_start = 32'hACE1_2468;
   localparam data_t lfsr_taps  = 32'h8020_0003;

   logic        mclk;
   logic        s_reset_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   addr_t       wb_adr;
   data_t       wb_dat_w;
   sel_t        wb_sel;
   data_t       wb_dat_r;
   logic        wb_ack;
   strap_t      strap;
   intr_src_t   intr_src;
   periph_rst_t periph_rst;
   core_cfg_t   core_cfg;
   data_t       mfunc_sel;
   data_t       irq_lines;

   // Register model
   data_t model_rst;
   data_t model_core;
   data_t model_mfunc;
   data_t model_mbox;
   data_t model_sw [8];
   data_t model_mask;
   data_t model_stat;
   int    acc_count;
   int    num_checks;
   int    seed;

   glbl_reg_top #(
      .MFUNC_RESET (32'hC000_0000),
      .LFSR_SEED   (32'hACE1_2468)
   ) i_glbl_reg_top (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .strap      (strap),
      .intr_src   (intr_src),
      .periph_rst (periph_rst),
      .core_cfg   (core_cfg),
      .mfunc_sel  (mfunc_sel),
      .irq_lines  (irq_lines)
   );

   initial begin
      mclk = 1'b0;
      forever begin
         #4 mclk = ~mclk;
      end
   end

   // --------------------
   // Reference functions
   function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                         input sel_t sel);
      data_t res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) res[8*b +: 8] = new_val[8*b +: 8];
      end
      return res;
   endfunction

   // Bit 13 feeds both uart2 and i2c1
   function automatic periph_rst_t decode_rst(input data_t r);
      periph_rst_t p;
      p.cpu_intf = r[0];
      p.qspim    = r[1];
      p.sspim    = r[2];
      p.uart     = {r[13], r[6], r[3]};
      p.i2cm     = {r[13], r[4]};
      p.usbh     = r[5];
      p.usbd     = r[7];
      p.cpu_core = r[11:8];
      p.sspis    = r[12];
      return p;
   endfunction

   function automatic core_cfg_t decode_core(input data_t r);
      core_cfg_t c;
      c.riscv_ctrl  = r[31:16];
      c.gpio_dgmode = r[8];
      c.soft_irq    = r[3];
      c.user_irq    = r[2:0];
      return c;
   endfunction

   // Register 2 reset value from the straps
   function automatic data_t core_reset_val(input strap_t s);
      data_t r;
      r = '0;
      if (s.cache_bypass) r[27:26] = 2'b11;
      if (s.sram_clk_edge) r[19:16] = 4'hF;
      return r;
   endfunction

   function automatic data_t lfsr_step(input data_t s);
      data_t nxt;
      nxt = {1'b0, s[31:1]};
      if (s[0]) nxt = nxt ^ lfsr_taps;
      return nxt;
   endfunction

   // State after n completed accesses
   function automatic data_t lfsr_after(input int n);
      data_t s;
      s = lfsr_start;
      for (int i = 0; i < n; i++) begin
         s = lfsr_step(s);
      end
      return s;
   endfunction

   // Status bit that each source lands in
   function automatic data_t source_bit(input int code, input int k);
      case (code)
         0:       return data_t'(1) << (8 + k);
         1:       return 32'h0000_0080;
         2:       return 32'h0000_0040;
         3:       return 32'h0000_0020;
         4, 5:    return 32'h0000_0010;
         6:       return 32'h0000_0008;
         default: return data_t'(1) << k;
      endcase
   endfunction

   // --------------------
   // Compare tasks
   task automatic abort_run;
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      num_checks++;
      if (act !== exp) begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_rst(input string name, input periph_rst_t exp, input periph_rst_t act);
      num_checks++;
      if (act !== exp) begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_cfg(input string name, input core_cfg_t exp, input core_cfg_t act);
      num_checks++;
      if (act !== exp) begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   // --------------------
   // Bus tasks sample ack at the edge ending the ack cycle
   task automatic bus_access(input logic we, input addr_t adr, input data_t wdat,
                             input sel_t sel, output data_t rdat);
      int waited;
      @(posedge mclk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      wb_sel   <= sel;
      waited = 0;
      @(posedge mclk);
      while (!wb_ack && waited < ack_limit) begin
         @(posedge mclk);
         waited++;
      end
      if (!wb_ack) begin
         $display("timeout: no ack from the DUT for address %h", adr);
         abort_run();
      end
      rdat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      acc_count++;
   endtask

   task automatic wb_write(input addr_t adr, input data_t wdat, input sel_t sel);
      data_t unused_rd;
      bus_access(1'b1, adr, wdat, sel, unused_rd);
   endtask

   task automatic wb_read(input addr_t adr, output data_t rdat);
      bus_access(1'b0, adr, '0, 4'hF, rdat);
   endtask

   task automatic read_check(input string name, input addr_t adr, input data_t exp);
      data_t rd;
      wb_read(adr, rd);
      check_data(name, exp, rd);
   endtask

   // One-cycle pulse on a single source
   task automatic pulse_source(input int code, input int k);
      @(posedge mclk);
      case (code)
         0:       intr_src.gpio  <= 24'h1 << k;
         1:       intr_src.ir    <= 1'b1;
         2:       intr_src.rtc   <= 1'b1;
         3:       intr_src.pwm   <= 1'b1;
         4:       intr_src.usbh  <= 1'b1;
         5:       intr_src.usbd  <= 1'b1;
         6:       intr_src.i2cm  <= 1'b1;
         default: intr_src.timer <= 3'h1 << k;
      endcase
      @(posedge mclk);
      intr_src <= '0;
   endtask

   // Pulse, poll status, mask, then clear by writing ones
   task automatic irq_source_test(input int code, input int k);
      data_t bit_exp;
      data_t rd;
      int    polls;
      bit_exp = source_bit(code, k);
      pulse_source(code, k);
      polls = 0;
      wb_read(ADR_INTR_STAT, rd);
      while ((rd & bit_exp) == '0 && polls < poll_limit) begin
         wb_read(ADR_INTR_STAT, rd);
         polls++;
      end
      if ((rd & bit_exp) == '0) begin
         $display("timeout: status bit for interrupt source %0d never set", code);
         abort_run();
      end
      model_stat = bit_exp;
      check_data("irq status", model_stat, rd);
      model_mask = data_t'($random(seed)) | bit_exp;
      wb_write(ADR_INTR_MASK, model_mask, 4'hF);
      @(posedge mclk);
      check_data("irq lines", model_mask & model_stat, irq_lines);
      read_check("irq mask", ADR_INTR_MASK, model_mask);
      wb_write(ADR_INTR_STAT, bit_exp, 4'hF);
      model_stat = '0;
      read_check("irq clear", ADR_INTR_STAT, model_stat);
      check_data("irq lines clear", '0, irq_lines);
   endtask

   // --------------------
   // Test sequence
   initial begin : main
      data_t wdat;
      data_t rd;
      sel_t  wsel;
      addr_t adr;
      addr_t unmapped [14];
      unmapped = '{5'h06, 5'h07, 5'h08, 5'h0B, 5'h0C, 5'h0D, 5'h18,
                   5'h19, 5'h1A, 5'h1B, 5'h1C, 5'h1D, 5'h1E, 5'h1F};
      seed       = 32'h9d08;
      acc_count  = 0;
      num_checks = 0;
      s_reset_n <= 1'b0;
      wb_cyc    <= 1'b0;
      wb_stb    <= 1'b0;
      wb_we     <= 1'b0;
      wb_adr    <= '0;
      wb_dat_w  <= '0;
      wb_sel    <= '0;
      intr_src  <= '0;
      // Straps with boot and cache bypass set and SRAM edge clear
      strap     <= {1'b1, 1'b1, 1'b0, 13'h0055};
      repeat (2) @(posedge mclk);
      s_reset_n <= 1'b1;

      // Reset values
      model_rst   = strap.riscv_boot ? 32'h0000_0103 : 32'h0000_0003;
      model_core  = core_reset_val(strap);
      model_mfunc = 32'hC000_0000;
      model_mbox  = '0;
      model_sw    = '{32'h8273_8343, 32'h0101_2025, 32'h0005_2000, 0, 0, 0, 0, 0};
      model_mask  = '0;
      model_stat  = '0;
      read_check("reset chip id", ADR_CHIP_ID, 32'h8268_2701);
      read_check("reset rst ctrl", ADR_RST_CTRL, model_rst);
      read_check("reset core cfg", ADR_CORE_CFG, model_core);
      read_check("reset mask", ADR_INTR_MASK, model_mask);
      read_check("reset status", ADR_INTR_STAT, model_stat);
      read_check("reset mfunc", ADR_MFUNC_SEL, model_mfunc);
      read_check("reset strap", ADR_STRAP, {16'h0000, strap});
      read_check("reset mailbox", ADR_MAILBOX, model_mbox);
      for (int i = 0; i < 8; i++) begin
         read_check("reset sw reg", ADR_SW_BASE + addr_t'(i), model_sw[i]);
      end
      check_rst("reset periph rst", decode_rst(32'h0000_0103), periph_rst);
      check_data("reset irq lines", '0, irq_lines);

      // Byte-enable writes to mailbox and software bank
      for (int r = 0; r < 9; r++) begin
         repeat (3) begin
            wdat = $random(seed);
            wsel = sel_t'($random(seed));
            adr  = (r == 8) ? ADR_MAILBOX : ADR_SW_BASE + addr_t'(r);
            wb_write(adr, wdat, wsel);
            if (r == 8) begin
               model_mbox = merge_bytes(model_mbox, wdat, wsel);
               read_check("mailbox byte write", adr, model_mbox);
            end else begin
               model_sw[r] = merge_bytes(model_sw[r], wdat, wsel);
               read_check("sw byte write", adr, model_sw[r]);
            end
         end
      end

      // Reset control writes starting with the shared bit 13
      for (int n = 0; n < 5; n++) begin
         wdat = (n == 0) ? 32'h0000_2000 : data_t'($random(seed));
         wsel = (n == 0) ? 4'hF : sel_t'($random(seed));
         wb_write(ADR_RST_CTRL, wdat, wsel);
         model_rst = merge_bytes(model_rst, wdat, wsel);
         @(posedge mclk);
         check_rst("periph rst decode", decode_rst(model_rst), periph_rst);
         read_check("rst ctrl readback", ADR_RST_CTRL, model_rst);
      end

      // Core configuration and pin select
      repeat (4) begin
         wdat = $random(seed);
         wsel = sel_t'($random(seed));
         wb_write(ADR_CORE_CFG, wdat, wsel);
         model_core = merge_bytes(model_core, wdat, wsel);
         @(posedge mclk);
         check_cfg("core cfg decode", decode_core(model_core), core_cfg);
         read_check("core cfg readback", ADR_CORE_CFG, model_core);
         wdat = $random(seed);
         wb_write(ADR_MFUNC_SEL, wdat, 4'hF);
         model_mfunc = wdat;
         @(posedge mclk);
         check_data("mfunc sel output", model_mfunc, mfunc_sel);
         read_check("mfunc sel readback", ADR_MFUNC_SEL, model_mfunc);
      end

      // Each interrupt source in turn
      irq_source_test(0, 0);
      irq_source_test(0, 23);
      irq_source_test(0, int'($unsigned($random(seed)) % 24));
      for (int c = 1; c < 7; c++) begin
         irq_source_test(c, 0);
      end
      for (int t = 0; t < 3; t++) begin
         irq_source_test(7, t);
      end

      // Set register followed by partial and full clear
      wdat = $random(seed);
      wsel = sel_t'($random(seed));
      wb_write(ADR_INTR_SET, wdat, wsel);
      model_stat = wdat & merge_bytes('0, '1, wsel);
      read_check("irq set", ADR_INTR_STAT, model_stat);
      read_check("irq set mirror", ADR_INTR_SET, model_stat);
      check_data("irq lines after set", model_mask & model_stat, irq_lines);
      wsel = sel_t'($random(seed));
      wb_write(ADR_INTR_STAT, '1, wsel);
      model_stat = model_stat & ~merge_bytes('0, '1, wsel);
      read_check("irq partial clear", ADR_INTR_STAT, model_stat);
      wb_write(ADR_INTR_STAT, '1, 4'hF);
      model_stat = '0;
      read_check("irq full clear", ADR_INTR_STAT, model_stat);

      // Random numbers track the access count
      repeat (6) begin
         wdat = lfsr_after(acc_count);
         wb_read(ADR_RANDOM, rd);
         check_data("random value", wdat, rd);
         wb_write(ADR_MAILBOX, rd, 4'hF);
         model_mbox = rd;
         read_check("mailbox random copy", ADR_MAILBOX, model_mbox);
      end

      // Unmapped addresses read zero before and after a write
      foreach (unmapped[i]) begin
         read_check("unmapped before write", unmapped[i], '0);
         wb_write(unmapped[i], $random(seed), 4'hF);
         read_check("unmapped after write", unmapped[i], '0);
      end

      if (num_checks > 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("no checks were run");
         abort_run();
      end
   end

endmodule

`default_nettype wire

//--- all.f
rtl/glbl_pkg.sv
rtl/glbl_wb_slave.sv
rtl/glbl_cfg_regs.sv
rtl/glbl_intr_ctrl.sv
rtl/glbl_lfsr.sv
rtl/glbl_reg_top.sv
bench/glbl_reg_tb.sv

//--- Makefile
# Verilator build, run and lint of the global register block

TOP := glbl_reg_tb
LOG := sim.log
RTL := rtl/glbl_pkg.sv rtl/glbl_wb_slave.sv rtl/glbl_cfg_regs.sv \
       rtl/glbl_intr_ctrl.sv rtl/glbl_lfsr.sv rtl/glbl_reg_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall $(RTL) --top-module glbl_reg_top

clean:
	rm -rf obj_dir $(LOG)
